/* design/mmu_settings.svh */
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// Virtual and physical page number widths
`define MMU_VPN_BITS 20
`define MMU_PPN_BITS 8

// Translation buffer size
`define MMU_TLB_ENTRIES 4

// Flat page table, indexed by the low vpn bits
`define MMU_PT_DEPTH 16
`define MMU_PT_IDX_BITS ($clog2(`MMU_PT_DEPTH))

`endif

/* design/mmu_pkg.sv */
`default_nettype none

`include "mmu_settings.svh"

package mmu_pkg;

    typedef enum logic [1:0] {
        PROT_R  = 2'd0,
        PROT_W  = 2'd1,
        PROT_RW = 2'd2,
        PROT_EX = 2'd3
    } page_prot_e;

    // A request never asks for RW
    typedef enum logic [1:0] {
        ACC_R  = 2'd0,
        ACC_W  = 2'd1,
        ACC_EX = 2'd3
    } access_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WALK  = 2'd1,
        RETRY = 2'd2
    } walk_state_e;

    typedef struct packed {
        logic                      valid;
        logic [`MMU_VPN_BITS-1:0]  vpn;   // Full tag, not just the index bits
        logic [`MMU_PPN_BITS-1:0]  ppn;
        page_prot_e                prot;
    } pte_t;

    typedef struct packed {
        logic [`MMU_VPN_BITS-1:0]  vpn;
        access_e                   acc;
    } xlate_req_t;

    typedef struct packed {
        logic [`MMU_PPN_BITS-1:0]  ppn;
        logic                      prot_fault;
        logic                      page_fault;
    } xlate_rsp_t;

endpackage

`default_nettype wire

/* design/mmu_tlb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_tlb import mmu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`MMU_VPN_BITS-1:0]  lookup_vpn_i,
    input  access_e                   lookup_acc_i,
    input  logic                      refill_i,
    input  pte_t                      refill_pte_i,
    input  logic                      flush_i,
    output logic                      hit_o,
    output logic                      prot_fault_o,
    output logic [`MMU_PPN_BITS-1:0]  ppn_o
);

    localparam int unsigned IDX_BITS = $clog2(`MMU_TLB_ENTRIES);
    localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(`MMU_TLB_ENTRIES - 1);

    // Boot mappings present right after reset
    localparam logic [`MMU_VPN_BITS-1:0] BOOT0_VPN = '0;
    localparam logic [`MMU_PPN_BITS-1:0] BOOT0_PPN = '0;
    localparam logic [`MMU_VPN_BITS-1:0] BOOT1_VPN = 'h0000A;
    localparam logic [`MMU_PPN_BITS-1:0] BOOT1_PPN = 'h0A;

    pte_t [`MMU_TLB_ENTRIES-1:0]  ent_q;
    logic [`MMU_TLB_ENTRIES-1:0]  hit_vec;
    logic [IDX_BITS-1:0]          rr_q;   // Next victim
    pte_t                         hit_ent;
    logic                         acc_ok;

    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            hit_vec[i] = ent_q[i].valid && (ent_q[i].vpn == lookup_vpn_i);
        end
    end

    // At most one entry matches, so an OR of the masked entries selects it
    always_comb begin
        hit_ent = '0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            hit_ent = hit_ent | (ent_q[i] & {$bits(pte_t){hit_vec[i]}});
        end
    end

    always_comb begin
        case (hit_ent.prot)
            PROT_RW: acc_ok = (lookup_acc_i == ACC_R) || (lookup_acc_i == ACC_W);
            PROT_R:  acc_ok = (lookup_acc_i == ACC_R);
            PROT_W:  acc_ok = (lookup_acc_i == ACC_W);
            PROT_EX: acc_ok = (lookup_acc_i == ACC_EX);
            default: acc_ok = 1'b0;
        endcase
    end

    assign hit_o        = |hit_vec;
    assign prot_fault_o = hit_o && !acc_ok;   // Low on a miss
    assign ppn_o        = hit_ent.ppn;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ent_q[0] <= '{valid: 1'b1, vpn: BOOT0_VPN, ppn: BOOT0_PPN, prot: PROT_EX};
            ent_q[1] <= '{valid: 1'b1, vpn: BOOT1_VPN, ppn: BOOT1_PPN, prot: PROT_RW};
            for (int i = 2; i < `MMU_TLB_ENTRIES; i++) begin
                ent_q[i] <= '0;
            end
            rr_q <= '0;
        end else if (refill_i) begin   // Refill wins over flush
            ent_q[rr_q] <= refill_pte_i;
            rr_q        <= (rr_q == LAST_IDX) ? '0 : rr_q + 1'b1;
        end else if (flush_i) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                ent_q[i].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/mmu_page_table.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_page_table import mmu_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         wr_i,
    input  logic [`MMU_PT_IDX_BITS-1:0]  wr_idx_i,
    input  pte_t                         wr_pte_i,
    input  logic [`MMU_PT_IDX_BITS-1:0]  rd_idx_i,
    output pte_t                         rd_pte_o
);

    logic [`MMU_PT_DEPTH-1:0]  valid_q;
    pte_t                      body_q [`MMU_PT_DEPTH];   // Valid field unused here
    pte_t                      rd_ent;
    pte_t                      rd_pte_q;

    // Valid bits
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i) begin
            valid_q[wr_idx_i] <= wr_pte_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            body_q[wr_idx_i] <= wr_pte_i;
        end
    end

    always_comb begin
        rd_ent       = body_q[rd_idx_i];
        rd_ent.valid = valid_q[rd_idx_i];
    end

    // Registered read, one cycle after the index
    always_ff @(posedge clk_i) begin
        rd_pte_q <= rd_ent;
    end

    assign rd_pte_o = rd_pte_q;

endmodule

`default_nettype wire

/* design/mmu_walk_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_walk_ctrl import mmu_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  xlate_req_t                   req_data_i,
    input  logic                         flush_i,
    input  logic                         tlb_hit_i,
    input  logic                         tlb_prot_fault_i,
    input  logic [`MMU_PPN_BITS-1:0]     tlb_ppn_i,
    input  pte_t                         pt_pte_i,
    output logic [`MMU_VPN_BITS-1:0]     lookup_vpn_o,
    output access_e                      lookup_acc_o,
    output logic                         refill_o,
    output pte_t                         refill_pte_o,
    output logic                         tlb_flush_o,
    output logic [`MMU_PT_IDX_BITS-1:0]  pt_rd_idx_o,
    output logic                         busy_o,
    output logic                         done_o,
    output xlate_rsp_t                   rsp_o
);

    walk_state_e  state_q;
    walk_state_e  state_d;
    xlate_req_t   req_q;
    xlate_req_t   cur_req;
    xlate_rsp_t   rsp_q;
    xlate_rsp_t   rsp_d;
    logic         done_q;
    logic         done_d;
    logic         accept;
    logic         pte_match;

    // Busy also covers the done cycle
    assign busy_o = (state_q != IDLE) || done_q;
    assign accept = req_i && !busy_o;

    // Live request in IDLE, latched one during a walk
    assign cur_req      = (state_q == IDLE) ? req_data_i : req_q;
    assign lookup_vpn_o = cur_req.vpn;
    assign lookup_acc_o = cur_req.acc;
    assign pt_rd_idx_o  = cur_req.vpn[`MMU_PT_IDX_BITS-1:0];

    // Table slot is shared by many pages, so check the full tag
    assign pte_match    = pt_pte_i.valid && (pt_pte_i.vpn == req_q.vpn);
    assign refill_o     = (state_q == WALK) && pte_match;
    assign refill_pte_o = pt_pte_i;

    assign tlb_flush_o = flush_i && !busy_o && !req_i;

    always_comb begin
        state_d = state_q;
        done_d  = 1'b0;
        rsp_d   = rsp_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (tlb_hit_i) begin
                        done_d           = 1'b1;
                        rsp_d.ppn        = tlb_ppn_i;
                        rsp_d.prot_fault = tlb_prot_fault_i;
                        rsp_d.page_fault = 1'b0;
                    end else begin
                        state_d = WALK;   // Table read already issued
                    end
                end
            end
            WALK: begin
                if (pte_match) begin
                    state_d = RETRY;
                end else begin
                    state_d          = IDLE;
                    done_d           = 1'b1;
                    rsp_d.ppn        = '0;
                    rsp_d.prot_fault = 1'b0;
                    rsp_d.page_fault = 1'b1;
                end
            end
            RETRY: begin
                state_d          = IDLE;
                done_d           = 1'b1;
                rsp_d.ppn        = tlb_ppn_i;
                rsp_d.prot_fault = tlb_prot_fault_i;
                rsp_d.page_fault = !tlb_hit_i;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_data_i;
        end
        rsp_q <= rsp_d;
    end

    assign done_o = done_q;
    assign rsp_o  = rsp_q;

endmodule

`default_nettype wire

/* design/mmu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_top import mmu_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  xlate_req_t                   req_data_i,
    input  logic                         flush_i,
    input  logic                         pt_wr_i,
    input  logic [`MMU_PT_IDX_BITS-1:0]  pt_idx_i,
    input  pte_t                         pt_data_i,
    output logic                         busy_o,
    output logic                         done_o,
    output xlate_rsp_t                   rsp_o
);

    logic [`MMU_VPN_BITS-1:0]     lookup_vpn;
    access_e                      lookup_acc;
    logic                         refill;
    pte_t                         refill_pte;
    logic                         tlb_flush;
    logic                         tlb_hit;
    logic                         tlb_prot_fault;
    logic [`MMU_PPN_BITS-1:0]     tlb_ppn;
    logic [`MMU_PT_IDX_BITS-1:0]  pt_rd_idx;
    pte_t                         pt_rd_pte;

    mmu_walk_ctrl u_walk_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .req_i            (req_i),
        .req_data_i       (req_data_i),
        .flush_i          (flush_i),
        .tlb_hit_i        (tlb_hit),
        .tlb_prot_fault_i (tlb_prot_fault),
        .tlb_ppn_i        (tlb_ppn),
        .pt_pte_i         (pt_rd_pte),
        .lookup_vpn_o     (lookup_vpn),
        .lookup_acc_o     (lookup_acc),
        .refill_o         (refill),
        .refill_pte_o     (refill_pte),
        .tlb_flush_o      (tlb_flush),
        .pt_rd_idx_o      (pt_rd_idx),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .rsp_o            (rsp_o)
    );

    mmu_tlb u_tlb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .lookup_vpn_i (lookup_vpn),
        .lookup_acc_i (lookup_acc),
        .refill_i     (refill),
        .refill_pte_i (refill_pte),
        .flush_i      (tlb_flush),
        .hit_o        (tlb_hit),
        .prot_fault_o (tlb_prot_fault),
        .ppn_o        (tlb_ppn)
    );

    mmu_page_table u_page_table (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wr_i     (pt_wr_i),
        .wr_idx_i (pt_idx_i),
        .wr_pte_i (pt_data_i),
        .rd_idx_i (pt_rd_idx),
        .rd_pte_o (pt_rd_pte)
    );

endmodule

`default_nettype wire

/* test/mmu_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;   // Released right after the last reset edge
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* test/mmu_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module mmu_chk import mmu_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         req_i,
    input  logic         busy_i,
    input  logic         done_i,
    input  logic         refill_i,
    input  walk_state_e  state_i
);

    done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done_o stayed high for a second cycle");

    // The core must hold off while a translation is in flight
    no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        busy_i |-> !req_i)
        else $error("request issued while busy_o was high");

    // WALK is the cycle right after the accepting edge
    refill_in_walk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill_i |-> $past(req_i && !busy_i))
        else $error("buffer refill without an accepted request one cycle earlier");

    idle_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> (state_i == IDLE))
        else $error("sequencer not in IDLE after a reset edge");

endmodule

`default_nettype wire

/* test/mmu_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_monitor import mmu_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  xlate_req_t                   req_data_i,
    input  logic                         flush_i,
    input  logic                         pt_wr_i,
    input  logic [`MMU_PT_IDX_BITS-1:0]  pt_idx_i,
    input  pte_t                         pt_data_i,
    input  logic                         busy_i,
    input  logic                         done_i,
    input  xlate_rsp_t                   rsp_i,
    input  xlate_rsp_t                   exp_rsp_i,
    input  logic [1:0]                   exp_lat_i,
    output int                           chk_cnt_o,
    output int                           err_cnt_o
);

    pte_t        tlb_m [`MMU_TLB_ENTRIES];
    pte_t        pt_m  [`MMU_PT_DEPTH];
    int          rr_m;
    xlate_rsp_t  want_rsp;
    int          want_lat;
    xlate_rsp_t  tab_rsp;
    logic [1:0]  tab_lat;
    int          lat_cnt;
    logic        pending = 1'b0;
    int          chk_cnt = 0;
    int          err_cnt = 0;

    assign chk_cnt_o = chk_cnt;
    assign err_cnt_o = err_cnt;

    // RW pages take reads and writes, every other page needs an exact match
    function automatic logic access_allowed(input page_prot_e prot, input access_e acc);
        case (prot)
            PROT_RW: return (acc == ACC_R) || (acc == ACC_W);
            PROT_R:  return acc == ACC_R;
            PROT_W:  return acc == ACC_W;
            default: return acc == ACC_EX;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
        chk_cnt++;
        if (expv !== actv) begin
            err_cnt++;
            $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expv, actv);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            tlb_m[i] = '0;
        end
        for (int i = 0; i < `MMU_PT_DEPTH; i++) begin
            pt_m[i] = '0;
        end
        tlb_m[0] = '{valid: 1'b1, vpn: 20'h00000, ppn: 8'h00, prot: PROT_EX};
        tlb_m[1] = '{valid: 1'b1, vpn: 20'h0000A, ppn: 8'h0A, prot: PROT_RW};
        rr_m     = 0;
    endtask

    // Result and latency of one request; a refill updates the model at once
    task automatic predict(input xlate_req_t req);
        int   slot;
        pte_t pte;
        slot = -1;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (tlb_m[i].valid && (tlb_m[i].vpn == req.vpn)) begin
                slot = i;
            end
        end
        pte      = pt_m[req.vpn[`MMU_PT_IDX_BITS-1:0]];
        want_rsp = '0;
        if (slot >= 0) begin
            want_lat            = 1;
            want_rsp.ppn        = tlb_m[slot].ppn;
            want_rsp.prot_fault = !access_allowed(tlb_m[slot].prot, req.acc);
        end else if (pte.valid && (pte.vpn == req.vpn)) begin
            want_lat            = 3;
            want_rsp.ppn        = pte.ppn;
            want_rsp.prot_fault = !access_allowed(pte.prot, req.acc);
            tlb_m[rr_m]         = pte;
            rr_m                = (rr_m + 1) % `MMU_TLB_ENTRIES;
        end else begin
            want_lat            = 2;
            want_rsp.page_fault = 1'b1;
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            reset_model();
            pending = 1'b0;
        end else begin
            compare("busy_o", 32'(pending), 32'(busy_i));   // High after acceptance up to done
            if (pending) begin
                lat_cnt++;
                if (done_i) begin
                    compare("rsp_o", 32'(want_rsp), 32'(rsp_i));
                    compare("done_o latency", 32'(want_lat), 32'(lat_cnt));
                    compare("rsp_o vs table", 32'(tab_rsp), 32'(rsp_i));
                    compare("done_o latency vs table", 32'(tab_lat), 32'(lat_cnt));
                    pending = 1'b0;
                end
            end else if (done_i) begin
                err_cnt++;
                $display("Unexpected done_o at %0t with no request outstanding", $time);
            end
            if (pt_wr_i) begin
                pt_m[pt_idx_i] = pt_data_i;
            end
            if (flush_i && !busy_i && !req_i) begin
                for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                    tlb_m[i].valid = 1'b0;
                end
            end
            if (req_i && !busy_i) begin
                predict(req_data_i);
                tab_rsp = exp_rsp_i;
                tab_lat = exp_lat_i;
                lat_cnt = 0;
                pending = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* test/mmu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_settings.svh"

module mmu_tb import mmu_pkg::*; ();

    localparam logic [1:0] OP_PTW     = 2'd0;
    localparam logic [1:0] OP_REQ     = 2'd1;
    localparam logic [1:0] OP_FLUSH   = 2'd2;
    localparam logic [1:0] LAT_HIT    = 2'd1;
    localparam logic [1:0] LAT_PF     = 2'd2;
    localparam logic [1:0] LAT_REFILL = 2'd3;
    localparam int         WAIT_LIMIT = 20;   // Cycles

    typedef struct packed {
        logic [1:0]                   kind;
        xlate_req_t                   req;
        logic [`MMU_PT_IDX_BITS-1:0]  idx;
        pte_t                         pte;
        xlate_rsp_t                   exp;
        logic [1:0]                   lat;
    } row_t;

    logic                         clk;
    logic                         rst_n;
    logic                         req;
    xlate_req_t                   req_data;
    logic                         flush;
    logic                         pt_wr;
    logic [`MMU_PT_IDX_BITS-1:0]  pt_idx;
    pte_t                         pt_data;
    logic                         busy;
    logic                         done;
    xlate_rsp_t                   rsp;
    xlate_rsp_t                   exp_rsp;
    logic [1:0]                   exp_lat;
    row_t                         rows [$];
    logic [31:0]                  rng;
    int                           timeouts;
    int                           chk_cnt;
    int                           err_cnt;

    mmu_clk_gen #(.PERIOD(40), .RST_CYCLES(4)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mmu_top DUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .req_data_i (req_data),
        .flush_i    (flush),
        .pt_wr_i    (pt_wr),
        .pt_idx_i   (pt_idx),
        .pt_data_i  (pt_data),
        .busy_o     (busy),
        .done_o     (done),
        .rsp_o      (rsp)
    );

    mmu_monitor u_monitor (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .req_i      (req),
        .req_data_i (req_data),
        .flush_i    (flush),
        .pt_wr_i    (pt_wr),
        .pt_idx_i   (pt_idx),
        .pt_data_i  (pt_data),
        .busy_i     (busy),
        .done_i     (done),
        .rsp_i      (rsp),
        .exp_rsp_i  (exp_rsp),
        .exp_lat_i  (exp_lat),
        .chk_cnt_o  (chk_cnt),
        .err_cnt_o  (err_cnt)
    );

    bind mmu_walk_ctrl mmu_chk u_chk (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .busy_i   (busy_o),
        .done_i   (done_o),
        .refill_i (refill_o),
        .state_i  (state_q)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_ptw(input logic [`MMU_PT_IDX_BITS-1:0] idx,
                           input logic [`MMU_VPN_BITS-1:0] vpn,
                           input logic [`MMU_PPN_BITS-1:0] ppn, input page_prot_e prot);
        row_t r;
        r      = '0;
        r.kind = OP_PTW;
        r.idx  = idx;
        r.pte  = '{valid: 1'b1, vpn: vpn, ppn: ppn, prot: prot};
        rows.push_back(r);
    endtask

    task automatic add_req(input logic [`MMU_VPN_BITS-1:0] vpn, input access_e acc,
                           input logic [`MMU_PPN_BITS-1:0] ppn, input logic prot_fault,
                           input logic page_fault, input logic [1:0] lat);
        row_t r;
        r                = '0;
        r.kind           = OP_REQ;
        r.req.vpn        = vpn;
        r.req.acc        = acc;
        r.exp.ppn        = ppn;
        r.exp.prot_fault = prot_fault;
        r.exp.page_fault = page_fault;
        r.lat            = lat;
        rows.push_back(r);
    endtask

    task automatic add_fault(input logic [`MMU_VPN_BITS-1:0] vpn, input access_e acc);
        add_req(vpn, acc, 8'h00, 1'b0, 1'b1, LAT_PF);
    endtask

    task automatic add_flush();
        row_t r;
        r      = '0;
        r.kind = OP_FLUSH;
        rows.push_back(r);
    endtask

    task automatic build_table();
        rng = 32'd60;
        add_req(20'h0000A, ACC_R,  8'h0A, 1'b0, 1'b0, LAT_HIT);
        add_req(20'h0000A, ACC_W,  8'h0A, 1'b0, 1'b0, LAT_HIT);
        add_req(20'h00000, ACC_EX, 8'h00, 1'b0, 1'b0, LAT_HIT);
        add_req(20'h0000A, ACC_EX, 8'h0A, 1'b1, 1'b0, LAT_HIT);
        add_req(20'h00000, ACC_R,  8'h00, 1'b1, 1'b0, LAT_HIT);
        add_ptw(4'h3, 20'h00123, 8'h23, PROT_RW);
        add_req(20'h00123, ACC_R,  8'h23, 1'b0, 1'b0, LAT_REFILL);   // Into entry 0
        add_req(20'h00123, ACC_R,  8'h23, 1'b0, 1'b0, LAT_HIT);
        add_req(20'h00123, ACC_W,  8'h23, 1'b0, 1'b0, LAT_HIT);
        add_fault(20'h00456, ACC_R);
        add_fault(20'h00456, ACC_R);
        add_fault(20'h10003, ACC_R);   // Slot 3 holds another tag
        for (int k = 0; k < 3; k++) begin
            rng = next_random(rng);
            add_fault({rng[19:4], 4'hF}, ACC_EX);   // Slot 15 stays empty
        end
        add_ptw(4'h4, 20'h00044, 8'h44, PROT_R);
        add_req(20'h00044, ACC_R,  8'h44, 1'b0, 1'b0, LAT_REFILL);   // Entry 1
        add_ptw(4'h5, 20'h00055, 8'h55, PROT_W);
        add_req(20'h00055, ACC_W,  8'h55, 1'b0, 1'b0, LAT_REFILL);   // Entry 2
        add_ptw(4'h7, 20'h00077, 8'h77, PROT_EX);
        add_req(20'h00077, ACC_EX, 8'h77, 1'b0, 1'b0, LAT_REFILL);   // Entry 3
        add_ptw(4'h8, 20'h00088, 8'h88, PROT_RW);
        add_req(20'h00088, ACC_R,  8'h88, 1'b0, 1'b0, LAT_REFILL);   // Wraps to entry 0
        add_fault(20'h00000, ACC_EX);
        add_req(20'h00123, ACC_R,  8'h23, 1'b0, 1'b0, LAT_REFILL);   // Entry 1
        add_req(20'h00055, ACC_R,  8'h55, 1'b1, 1'b0, LAT_HIT);
        add_req(20'h00044, ACC_W,  8'h44, 1'b1, 1'b0, LAT_REFILL);   // Fault after retry
        add_req(20'h00077, ACC_EX, 8'h77, 1'b0, 1'b0, LAT_HIT);
        add_flush();
        add_fault(20'h0000A, ACC_R);
        add_ptw(4'hA, 20'h0000A, 8'h0A, PROT_RW);
        add_req(20'h0000A, ACC_W,  8'h0A, 1'b0, 1'b0, LAT_REFILL);
        add_req(20'h0000A, ACC_R,  8'h0A, 1'b0, 1'b0, LAT_HIT);
        add_req(20'h00088, ACC_R,  8'h88, 1'b0, 1'b0, LAT_REFILL);
    endtask

    task automatic wait_reset();
        int cyc;
        cyc = 0;
        while (!rst_n && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Timeout at %0t: reset was never released", $time);
        end
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (busy && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout at %0t: busy_o did not drop", $time);
        end
    endtask

    task automatic apply_row(input row_t r, input int n);
        int cyc;
        wait_idle();
        case (r.kind)
            OP_PTW: begin
                pt_wr   = 1'b1;
                pt_idx  = r.idx;
                pt_data = r.pte;
                @(negedge clk);
                pt_wr   = 1'b0;
            end
            OP_FLUSH: begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            default: begin
                req      = 1'b1;
                req_data = r.req;
                exp_rsp  = r.exp;
                exp_lat  = r.lat;
                @(negedge clk);
                req = 1'b0;
                cyc = 1;
                while (!done && cyc < WAIT_LIMIT) begin
                    @(negedge clk);
                    cyc++;
                end
                if (!done) begin
                    timeouts++;
                    $display("Timeout at %0t: no done_o for table row %0d", $time, n);
                end
            end
        endcase
    endtask

    initial begin
        timeouts = 0;
        req      = 1'b0;
        req_data = '0;
        flush    = 1'b0;
        pt_wr    = 1'b0;
        pt_idx   = '0;
        pt_data  = '0;
        exp_rsp  = '0;
        exp_lat  = '0;
        build_table();
        wait_reset();
        foreach (rows[n]) begin
            apply_row(rows[n], n);
        end
        @(negedge clk);
        $display("Rows: %0d, checks: %0d, errors: %0d, timeouts: %0d",
                 rows.size(), chk_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/mmu_pkg.sv
design/mmu_tlb.sv
design/mmu_page_table.sv
design/mmu_walk_ctrl.sv
design/mmu_top.sv
test/mmu_clk_gen.sv
test/mmu_chk.sv
test/mmu_monitor.sv
test/mmu_tb.sv

/* Makefile */
SIM = obj_dir/mmu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module mmu_tb -f files.f -o mmu_sim

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
